// File: verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////

    localparam int opcode_bits  = 7;
    localparam int funct3_bits  = 3;
    localparam int funct7_bits  = 7;
    localparam int reg_idx_bits = 5;
    localparam int fmt_bits     = 3;

    ////////////////////////////////////////
    // rv32i major opcodes
    ////////////////////////////////////////

    localparam logic [opcode_bits-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_bits-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_bits-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_bits-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_bits-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_bits-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_bits-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_bits-1:0] op_op_imm = 7'b0010011;
    localparam logic [opcode_bits-1:0] op_op     = 7'b0110011;

    // op_imm funct3 codes that carry a shift amount
    localparam logic [funct3_bits-1:0] funct3_sll = 3'b001;
    localparam logic [funct3_bits-1:0] funct3_srl = 3'b101;

    // instruction format codes
    localparam logic [fmt_bits-1:0] fmt_r = 3'd0;
    localparam logic [fmt_bits-1:0] fmt_i = 3'd1;
    localparam logic [fmt_bits-1:0] fmt_s = 3'd2;
    localparam logic [fmt_bits-1:0] fmt_b = 3'd3;
    localparam logic [fmt_bits-1:0] fmt_u = 3'd4;
    localparam logic [fmt_bits-1:0] fmt_j = 3'd5;

    ////////////////////////////////////////
    // one instruction word, six layouts
    ////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [funct7_bits-1:0]  funct7;
            logic [reg_idx_bits-1:0] rs2;
            logic [reg_idx_bits-1:0] rs1;
            logic [funct3_bits-1:0]  funct3;
            logic [reg_idx_bits-1:0] rd;
            logic [opcode_bits-1:0]  opcode;
        } r;
        struct packed {
            logic [11:0]             imm_11_0;
            logic [reg_idx_bits-1:0] rs1;
            logic [funct3_bits-1:0]  funct3;
            logic [reg_idx_bits-1:0] rd;
            logic [opcode_bits-1:0]  opcode;
        } i;
        struct packed {
            logic [6:0]              imm_11_5;
            logic [reg_idx_bits-1:0] rs2;
            logic [reg_idx_bits-1:0] rs1;
            logic [funct3_bits-1:0]  funct3;
            logic [4:0]              imm_4_0;
            logic [opcode_bits-1:0]  opcode;
        } s;
        struct packed {
            logic                    imm_12;
            logic [5:0]              imm_10_5;
            logic [reg_idx_bits-1:0] rs2;
            logic [reg_idx_bits-1:0] rs1;
            logic [funct3_bits-1:0]  funct3;
            logic [3:0]              imm_4_1;
            logic                    imm_11;
            logic [opcode_bits-1:0]  opcode;
        } b;
        struct packed {
            logic [19:0]             imm_31_12;
            logic [reg_idx_bits-1:0] rd;
            logic [opcode_bits-1:0]  opcode;
        } u;
        struct packed {
            logic                    imm_20;
            logic [9:0]              imm_10_1;
            logic                    imm_11;
            logic [7:0]              imm_19_12;
            logic [reg_idx_bits-1:0] rd;
            logic [opcode_bits-1:0]  opcode;
        } j;
        logic [31:0] raw;
    } instr_u;

endpackage

// File: verilog/instr_receiver.sv
`timescale 1ns/1ps

module instr_receiver (
    input  logic                  clk,
    input  logic                  reset,
    // four-phase link from producer
    input  logic                  in_req,
    input  logic [31:0]           in_instr,
    output logic                  in_ack,
    // holding register toward sender
    input  logic                  take,
    output logic                  hold_valid,
    output rv_decode_pkg::instr_u hold_instr
);

    import rv_decode_pkg::*;

    logic accept;

    ////////////////////////////////////////
    // four-phase slave
    ////////////////////////////////////////

    // new word only when idle and the holding slot is free
    assign accept = in_req && !in_ack && !hold_valid;

    // in_ack low: idle, waiting for req
    // in_ack high: acked, waiting for req low
    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // one-entry holding register
    ////////////////////////////////////////

    // set on accept, cleared when sender takes it
    // both cannot happen on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (take) begin
            hold_valid <= 1'b0;
        end
    end

    // payload, captured with the ack edge
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_instr.raw <= in_instr;
        end
    end

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::instr_u instr,
    output logic [31:0]           imm
);

    import rv_decode_pkg::*;

    logic is_shift;

    // slli / srli / srai carry a 5-bit shamt in bits 24..20
    assign is_shift = (instr.i.opcode == op_op_imm) &&
                      ((instr.i.funct3 == funct3_sll) ||
                       (instr.i.funct3 == funct3_srl));

    ////////////////////////////////////////
    // immediate select by opcode
    ////////////////////////////////////////

    always_comb begin
        case (instr.r.opcode)
            // i type
            op_op_imm,
            op_load,
            op_jalr: begin
                if (is_shift) begin
                    // zero-extended shamt, funct7 bits dropped
                    imm = {27'd0, instr.i.imm_11_0[4:0]};
                end else begin
                    imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
                end
            end
            // s type, split 12 bits
            op_store: begin
                imm = {{20{instr.s.imm_11_5[6]}},
                       instr.s.imm_11_5,
                       instr.s.imm_4_0};
            end
            // b type, 13 bits, lsb always zero
            op_branch: begin
                imm = {{19{instr.b.imm_12}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};
            end
            // j type, 21 bits, lsb always zero
            op_jal: begin
                imm = {{11{instr.j.imm_20}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            // u type, upper 20 bits
            op_lui,
            op_auipc: begin
                imm = {instr.u.imm_31_12, 12'd0};
            end
            // r type and anything unknown
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

// File: verilog/ctrl_decode.sv
`timescale 1ns/1ps

module ctrl_decode (
    input  rv_decode_pkg::instr_u                   instr,
    output logic [rv_decode_pkg::fmt_bits-1:0]      fmt,
    output logic                                    illegal,
    output logic [rv_decode_pkg::reg_idx_bits-1:0]  rd,
    output logic [rv_decode_pkg::reg_idx_bits-1:0]  rs1,
    output logic [rv_decode_pkg::reg_idx_bits-1:0]  rs2,
    output logic                                    use_rd,
    output logic                                    use_rs1,
    output logic                                    use_rs2
);

    import rv_decode_pkg::*;

    ////////////////////////////////////////
    // opcode to format
    ////////////////////////////////////////

    always_comb begin
        illegal = 1'b0;
        case (instr.r.opcode)
            op_op: begin
                fmt = fmt_r;
            end
            op_op_imm,
            op_load,
            op_jalr: begin
                fmt = fmt_i;
            end
            op_store: begin
                fmt = fmt_s;
            end
            op_branch: begin
                fmt = fmt_b;
            end
            op_lui,
            op_auipc: begin
                fmt = fmt_u;
            end
            op_jal: begin
                fmt = fmt_j;
            end
            default: begin
                // fence, system, compressed etc.
                fmt     = fmt_i;
                illegal = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////
    // register use flags
    ////////////////////////////////////////

    // illegal words use no registers at all
    always_comb begin
        use_rd  = !illegal && ((fmt == fmt_r) || (fmt == fmt_i) ||
                               (fmt == fmt_u) || (fmt == fmt_j));
        use_rs1 = !illegal && ((fmt == fmt_r) || (fmt == fmt_i) ||
                               (fmt == fmt_s) || (fmt == fmt_b));
        use_rs2 = !illegal && ((fmt == fmt_r) || (fmt == fmt_s) ||
                               (fmt == fmt_b));
    end

    // index fields sit at the same bits in every layout that has them
    // unused index reads as x0
    assign rd  = use_rd  ? instr.r.rd  : '0;
    assign rs1 = use_rs1 ? instr.r.rs1 : '0;
    assign rs2 = use_rs2 ? instr.r.rs2 : '0;

endmodule

// File: verilog/decode_sender.sv
`timescale 1ns/1ps

module decode_sender (
    input  logic                                   clk,
    input  logic                                   reset,
    // from holding register and decoders
    input  logic                                   hold_valid,
    input  logic [31:0]                            imm,
    input  logic [rv_decode_pkg::fmt_bits-1:0]     fmt,
    input  logic                                   illegal,
    input  logic [rv_decode_pkg::reg_idx_bits-1:0] rd,
    input  logic [rv_decode_pkg::reg_idx_bits-1:0] rs1,
    input  logic [rv_decode_pkg::reg_idx_bits-1:0] rs2,
    input  logic                                   use_rd,
    input  logic                                   use_rs1,
    input  logic                                   use_rs2,
    output logic                                   take,
    // four-phase link to consumer
    input  logic                                   out_ack,
    output logic                                   out_req,
    output logic [31:0]                            out_imm,
    output logic [rv_decode_pkg::fmt_bits-1:0]     out_fmt,
    output logic                                   out_illegal,
    output logic [rv_decode_pkg::reg_idx_bits-1:0] out_rd,
    output logic [rv_decode_pkg::reg_idx_bits-1:0] out_rs1,
    output logic [rv_decode_pkg::reg_idx_bits-1:0] out_rs2,
    output logic                                   out_use_rd,
    output logic                                   out_use_rs1,
    output logic                                   out_use_rs2
);

    import rv_decode_pkg::*;

    logic full;

    // load pulse, also frees the receiver slot
    assign take = hold_valid && !full;

    ////////////////////////////////////////
    // four-phase master
    ////////////////////////////////////////

    // full & out_req: waiting for ack high
    // full & !out_req: waiting for ack low
    always_ff @(posedge clk) begin
        if (reset) begin
            full    <= 1'b0;
            out_req <= 1'b0;
        end else if (take) begin
            full    <= 1'b1;
            out_req <= 1'b1;
        end else if (full && out_req && out_ack) begin
            out_req <= 1'b0;
        end else if (full && !out_req && !out_ack) begin
            full <= 1'b0;
        end
    end

    // output fields, frozen while full
    always_ff @(posedge clk) begin
        if (take) begin
            out_imm     <= imm;
            out_fmt     <= fmt[fmt_bits-1:0];
            out_illegal <= illegal;
            out_rd      <= rd;
            out_rs1     <= rs1;
            out_rs2     <= rs2;
            out_use_rd  <= use_rd;
            out_use_rs1 <= use_rs1;
            out_use_rs2 <= use_rs2;
        end
    end

endmodule

// File: verilog/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top (
    input  logic                                   clk,
    input  logic                                   reset,
    // producer side
    input  logic                                   in_req,
    input  logic [31:0]                            in_instr,
    output logic                                   in_ack,
    // consumer side
    input  logic                                   out_ack,
    output logic                                   out_req,
    output logic [31:0]                            out_imm,
    output logic [rv_decode_pkg::fmt_bits-1:0]     out_fmt,
    output logic                                   out_illegal,
    output logic [rv_decode_pkg::reg_idx_bits-1:0] out_rd,
    output logic [rv_decode_pkg::reg_idx_bits-1:0] out_rs1,
    output logic [rv_decode_pkg::reg_idx_bits-1:0] out_rs2,
    output logic                                   out_use_rd,
    output logic                                   out_use_rs1,
    output logic                                   out_use_rs2
);

    import rv_decode_pkg::*;

    // holding register link
    logic   hold_valid;
    instr_u hold_instr;
    logic   take;

    // decoded fields of the held word
    logic [31:0]             imm;
    logic [fmt_bits-1:0]     fmt;
    logic                    illegal;
    logic [reg_idx_bits-1:0] rd;
    logic [reg_idx_bits-1:0] rs1;
    logic [reg_idx_bits-1:0] rs2;
    logic                    use_rd;
    logic                    use_rs1;
    logic                    use_rs2;

    ////////////////////////////////////////
    // input, decode, output
    ////////////////////////////////////////

    instr_receiver instr_receiver_inst (
        .clk        (clk),
        .reset      (reset),
        .in_req     (in_req),
        .in_instr   (in_instr),
        .in_ack     (in_ack),
        .take       (take),
        .hold_valid (hold_valid),
        .hold_instr (hold_instr)
    );

    imm_gen imm_gen_inst (
        .instr (hold_instr),
        .imm   (imm)
    );

    ctrl_decode ctrl_decode_inst (
        .instr   (hold_instr),
        .fmt     (fmt),
        .illegal (illegal),
        .rd      (rd),
        .rs1     (rs1),
        .rs2     (rs2),
        .use_rd  (use_rd),
        .use_rs1 (use_rs1),
        .use_rs2 (use_rs2)
    );

    decode_sender decode_sender_inst (
        .clk         (clk),
        .reset       (reset),
        .hold_valid  (hold_valid),
        .imm         (imm),
        .fmt         (fmt),
        .illegal     (illegal),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .use_rd      (use_rd),
        .use_rs1     (use_rs1),
        .use_rs2     (use_rs2),
        .take        (take),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .out_imm     (out_imm),
        .out_fmt     (out_fmt),
        .out_illegal (out_illegal),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_use_rd  (out_use_rd),
        .out_use_rs1 (out_use_rs1),
        .out_use_rs2 (out_use_rs2)
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int half_period_ns = 50;
    localparam int reset_cycles   = 16;

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: verif/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// sign-extend the low bits of v
function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    logic signed [31:0] t;
    t = $signed(v << (32 - bits));
    return t >>> (32 - bits);
endfunction

// only the nine rv32i major opcodes are supported
function automatic logic model_illegal(input logic [31:0] w);
    case (w[6:0])
        op_lui, op_auipc, op_jal, op_jalr, op_branch,
        op_load, op_store, op_op_imm, op_op: return 1'b0;
        default: return 1'b1;
    endcase
endfunction

function automatic logic [2:0] model_fmt(input logic [31:0] w);
    case (w[6:0])
        op_op: return fmt_r;
        op_store: return fmt_s;
        op_branch: return fmt_b;
        op_lui, op_auipc: return fmt_u;
        op_jal: return fmt_j;
        // i type, and the illegal fallback
        default: return fmt_i;
    endcase
endfunction

function automatic logic [31:0] model_imm(input logic [31:0] w);
    case (w[6:0])
        op_op_imm, op_load, op_jalr: begin
            // funct3 x01 on op_imm: slli, srli, srai
            if (w[6:0] == op_op_imm && w[13:12] == 2'b01) begin
                return {27'd0, w[24:20]};
            end
            return sext({20'd0, w[31:20]}, 12);
        end
        op_store: return sext({20'd0, w[31:25], w[11:7]}, 12);
        op_branch: return sext({19'd0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
        op_jal: return sext({11'd0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        op_lui, op_auipc: return w & 32'hfffff000;
        default: return 32'd0;
    endcase
endfunction

// {use_rd, use_rs1, use_rs2}
function automatic logic [2:0] model_use(input logic [31:0] w);
    logic [2:0] f;
    f = model_fmt(w);
    if (model_illegal(w)) begin
        return 3'b000;
    end
    case (f)
        fmt_r: return 3'b111;
        fmt_i: return 3'b110;
        fmt_s, fmt_b: return 3'b011;
        default: return 3'b100;
    endcase
endfunction

// {rd, rs1, rs2}, zero where unused
function automatic logic [14:0] model_regs(input logic [31:0] w);
    logic [2:0] u;
    u = model_use(w);
    return {u[2] ? w[11:7] : 5'd0, u[1] ? w[19:15] : 5'd0, u[0] ? w[24:20] : 5'd0};
endfunction

`endif

// File: verif/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode;

    import rv_decode_pkg::*;

    `include "decode_model.svh"

    localparam int num_words       = 400;
    localparam int cycles_per_word = 40;
    localparam int reset_cycles    = 16;
    localparam int clk_period_ns   = 100;
    localparam int watchdog_ns     = (num_words * cycles_per_word + reset_cycles) * clk_period_ns;
    localparam int drain_cycles    = 8;
    localparam logic [31:0] random_seed = 32'h4d6dcd6c;

    // hand-assembled words, one per opcode plus shifts, system and compressed
    localparam int num_directed = 16;
    localparam logic [31:0] directed_words [num_directed] = '{
        32'habcde2b7, 32'hfffff097, 32'hfe1ff0ef, 32'hffc08067,
        32'hfe208ee3, 32'hff812183, 32'hfe512a23, 32'hfff10093,
        32'h01f11093, 32'h00515093, 32'h40715093, 32'h002081b3,
        32'h402081b3, 32'h00000073, 32'h0000000f, 32'h00004501
    };
    localparam logic [6:0] legal_opcodes [9] = '{
        op_lui, op_auipc, op_jal, op_jalr, op_branch,
        op_load, op_store, op_op_imm, op_op
    };

    logic        clk;
    logic        reset;
    logic        in_req;
    logic [31:0] in_instr;
    logic        in_ack;
    logic        out_ack;
    logic        out_req;
    logic [31:0] out_imm;
    logic [2:0]  out_fmt;
    logic        out_illegal;
    logic [4:0]  out_rd;
    logic [4:0]  out_rs1;
    logic [4:0]  out_rs2;
    logic        out_use_rd;
    logic        out_use_rs1;
    logic        out_use_rs2;
    logic [53:0] out_fields;

    // scoreboard
    logic [31:0] expected_q [$];
    logic [31:0] exp_word;
    int          received;
    int          cycle_cnt = 0;
    int          word_seed = random_seed;
    // separate stream for the consumer delays
    int          delay_seed = random_seed + 1;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    rv_decode_top rv_decode_top_inst (
        .clk         (clk),
        .reset       (reset),
        .in_req      (in_req),
        .in_instr    (in_instr),
        .in_ack      (in_ack),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .out_imm     (out_imm),
        .out_fmt     (out_fmt),
        .out_illegal (out_illegal),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_use_rd  (out_use_rd),
        .out_use_rs1 (out_use_rs1),
        .out_use_rs2 (out_use_rs2)
    );

    assign out_fields = {out_imm, out_fmt, out_illegal, out_rd, out_rs1, out_rs2,
                         out_use_rd, out_use_rs1, out_use_rs2};

    always @(posedge clk) begin
        if (cycle_cnt < 1000) begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // error reporting
    ////////////////////////////////////////

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        stop_run();
    endtask

    task automatic protocol_error(input string what);
        $display("ERROR: %s", what);
        stop_run();
    endtask

    ////////////////////////////////////////
    // assertions
    ////////////////////////////////////////

    // posedges 2..17, covering reset and the edge after it
    reset_quiet: assert property (@(posedge clk)
        (cycle_cnt >= 1 && cycle_cnt <= reset_cycles) |-> (!in_ack && !out_req))
        else value_mismatch("reset", 32'd0, {30'd0, $sampled(in_ack), $sampled(out_req)});

    imm_check: assert property (@(posedge clk) disable iff (reset)
        out_req |-> out_imm == model_imm(exp_word))
        else value_mismatch("imm", model_imm($sampled(exp_word)), $sampled(out_imm));
    fmt_check: assert property (@(posedge clk) disable iff (reset)
        out_req |-> out_fmt == model_fmt(exp_word))
        else value_mismatch("fmt", 32'(model_fmt($sampled(exp_word))), 32'($sampled(out_fmt)));
    illegal_check: assert property (@(posedge clk) disable iff (reset)
        out_req |-> out_illegal == model_illegal(exp_word))
        else value_mismatch("illegal", 32'(model_illegal($sampled(exp_word))),
                            32'($sampled(out_illegal)));
    use_check: assert property (@(posedge clk) disable iff (reset)
        out_req |-> {out_use_rd, out_use_rs1, out_use_rs2} == model_use(exp_word))
        else value_mismatch("use flags", 32'(model_use($sampled(exp_word))),
                            32'($sampled({out_use_rd, out_use_rs1, out_use_rs2})));
    regs_check: assert property (@(posedge clk) disable iff (reset)
        out_req |-> {out_rd, out_rs1, out_rs2} == model_regs(exp_word))
        else value_mismatch("rd rs1 rs2", 32'(model_regs($sampled(exp_word))),
                            32'($sampled({out_rd, out_rs1, out_rs2})));

    // four-phase rules on both links
    out_hold: assert property (@(posedge clk) disable iff (reset)
        $fell(out_req) |-> $past(out_ack))
        else protocol_error("out_req dropped before out_ack was raised");
    out_stable: assert property (@(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> $stable(out_fields))
        else protocol_error("output fields changed while out_req was high");
    in_ack_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else protocol_error("in_ack raised without in_req");

    ////////////////////////////////////////
    // producer
    ////////////////////////////////////////

    task automatic send_word(input logic [31:0] word);
        @(negedge clk);
        in_instr = word;
        in_req   = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        expected_q.push_back(word);
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    initial begin : producer
        logic [31:0] word;
        int          pick;
        in_req   = 1'b0;
        in_instr = 32'd0;
        // first request goes up while reset is still high
        for (int k = 0; k < num_directed; k++) begin
            send_word(directed_words[k]);
        end
        // random fill, mostly legal opcodes
        repeat (num_words - num_directed) begin
            word = $random(word_seed);
            pick = $random(word_seed) & 15;
            if (pick < 14) begin
                word[6:0] = legal_opcodes[pick % 9];
            end
            send_word(word);
        end
        wait (received == num_words);
        // a duplicated word would show up within a few cycles
        repeat (drain_cycles) @(negedge clk);
        if (out_req || expected_q.size() != 0) begin
            protocol_error("extra or missing words at the end of the run");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    ////////////////////////////////////////
    // consumer with random back-pressure
    ////////////////////////////////////////

    initial begin : consumer
        int delay;
        out_ack  = 1'b0;
        exp_word = 32'd0;
        received = 0;
        wait (!reset);
        forever begin
            @(negedge clk);
            if (out_req) begin
                assert (expected_q.size() != 0)
                    else protocol_error("out_req raised with no word outstanding");
                exp_word = expected_q[0];
                delay = $random(delay_seed) & 7;
                repeat (delay) @(negedge clk);
                out_ack = 1'b1;
                while (out_req) @(negedge clk);
                delay = $random(delay_seed) & 7;
                repeat (delay) @(negedge clk);
                out_ack = 1'b0;
                void'(expected_q.pop_front());
                received++;
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        protocol_error("watchdog expired before all words came back");
    end

endmodule

// File: rv_decode.f
+incdir+verif
verilog/rv_decode_pkg.sv
verilog/instr_receiver.sv
verilog/imm_gen.sv
verilog/ctrl_decode.sv
verilog/decode_sender.sv
verilog/rv_decode_top.sv
verif/tb_clock_gen.sv
verif/tb_rv_decode.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_rv_decode
build_dir=obj_dir
sim_exe=sim_rv_decode
log_file=sim.log

verilator --binary --timing --assert \
    --top-module "$top" \
    -f rv_decode.f \
    -Mdir "$build_dir" \
    -o "$sim_exe"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q ">>> FAIL" "$log_file"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failure"
exit 0
